//--- logic/vga_pkg.sv
package vga_pkg;

  typedef logic [15:0] coord_t;
  typedef logic [7:0]  pal_idx_t;
  // red in the top byte, then green, then blue
  typedef logic [23:0] colour_t;
  typedef logic [1:0]  lane_addr_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_BUS,
    FETCH_LOOKUP,
    FETCH_STORE
  } fetch_state_t;

  // horizontal timing in pixels
  localparam coord_t H_ACTIVE = 16;
  localparam coord_t H_FRONT  = 2;
  localparam coord_t H_SYNC   = 4;
  localparam coord_t H_BACK   = 26;
  localparam coord_t H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // vertical timing in lines
  localparam coord_t V_ACTIVE = 4;
  localparam coord_t V_FRONT  = 1;
  localparam coord_t V_SYNC   = 2;
  localparam coord_t V_BACK   = 1;
  localparam coord_t V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  localparam int PIX_PER_WORD   = 4;
  localparam int WORDS_PER_LINE = H_ACTIVE / PIX_PER_WORD;
  localparam int PAL_ENTRIES    = 256;

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

  typedef logic [31:0] adr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  sel_t;
  // slave side is word addressed
  typedef logic [10:0] reg_adr_t;

  // palette window 0x000..0x0ff, matched on the top three address bits
  localparam logic [2:0] PAL_REGION = 3'h0;

  localparam reg_adr_t REG_BASE = 11'h500;
  localparam reg_adr_t REG_CTRL = 11'h501;

  // control register fields
  localparam int CTRL_EN_BIT = 0;

  localparam adr_t BASE_RESET = 32'hC000_0000;

endpackage

//--- logic/vga_regs.sv
`timescale 1ns/1ps

module vga_regs (
  input  logic              clk_i,
  input  logic              rst_i,
  input  bus_pkg::reg_adr_t slave_adr_i,
  input  bus_pkg::data_t    slave_dat_i,
  input  bus_pkg::sel_t     slave_sel_i,
  input  logic              slave_we_i,
  input  logic              slave_cyc_i,
  input  logic              slave_stb_i,
  output bus_pkg::data_t    slave_dat_o,
  output logic              slave_ack_o,
  output bus_pkg::adr_t     base_addr_o,
  output logic              disp_en_o,
  output logic              pal_we_o,
  output vga_pkg::pal_idx_t pal_wr_idx_o,
  output vga_pkg::colour_t  pal_wr_colour_o
);

  typedef enum logic {
    SLV_IDLE,
    SLV_ACK
  } slv_state_t;

  slv_state_t     state;
  logic           req;
  bus_pkg::data_t ctrl_q;

  function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old_val,
                                                 input bus_pkg::data_t new_val,
                                                 input bus_pkg::sel_t  sel);
    bus_pkg::data_t res;
    res = old_val;
    for (int i = 0; i < $bits(bus_pkg::sel_t); i++) begin
      if (sel[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // requests are only taken from idle
  assign req = (state == SLV_IDLE) && slave_cyc_i && slave_stb_i;

  assign pal_we_o        = req && slave_we_i && (slave_adr_i[10:8] == bus_pkg::PAL_REGION);
  assign pal_wr_idx_o    = slave_adr_i[7:0];
  assign pal_wr_colour_o = slave_dat_i[23:0];

  assign slave_ack_o = (state == SLV_ACK);
  assign disp_en_o   = ctrl_q[bus_pkg::CTRL_EN_BIT];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state       <= SLV_IDLE;
      base_addr_o <= bus_pkg::BASE_RESET;
      ctrl_q      <= '0;
    end else begin
      case (state)
        SLV_IDLE: begin
          if (req) begin
            state <= SLV_ACK;
            if (slave_we_i && slave_adr_i == bus_pkg::REG_BASE) begin
              base_addr_o <= merge_bytes(base_addr_o, slave_dat_i, slave_sel_i);
            end
            if (slave_we_i && slave_adr_i == bus_pkg::REG_CTRL) begin
              ctrl_q <= merge_bytes(ctrl_q, slave_dat_i, slave_sel_i);
            end
          end
        end
        SLV_ACK: state <= SLV_IDLE;
        default: state <= SLV_IDLE;
      endcase
    end
  end

  // read data is presented together with ack
  always_ff @(posedge clk_i) begin
    if (req && !slave_we_i) begin
      case (slave_adr_i)
        bus_pkg::REG_BASE: slave_dat_o <= base_addr_o;
        bus_pkg::REG_CTRL: slave_dat_o <= ctrl_q;
        default:           slave_dat_o <= '0;
      endcase
    end
  end

endmodule

//--- logic/vga_fetch.sv
`timescale 1ns/1ps

module vga_fetch (
  input  logic                clk_i,
  input  logic                rst_i,
  input  bus_pkg::adr_t       base_addr_i,
  input  logic                disp_en_i,
  input  logic                line_start_i,
  input  vga_pkg::coord_t     line_y_i,
  input  bus_pkg::data_t      master_dat_i,
  input  logic                master_ack_i,
  output bus_pkg::adr_t       master_adr_o,
  output logic                master_cyc_o,
  output logic                master_stb_o,
  output logic                master_we_o,
  output bus_pkg::sel_t       master_sel_o,
  output vga_pkg::pal_idx_t   lane_idx0_o,
  output vga_pkg::pal_idx_t   lane_idx1_o,
  output vga_pkg::pal_idx_t   lane_idx2_o,
  output vga_pkg::pal_idx_t   lane_idx3_o,
  output logic                wr_en_o,
  output logic                wr_bank_o,
  output vga_pkg::lane_addr_t wr_word_o
);

  vga_pkg::fetch_state_t state;
  vga_pkg::lane_addr_t   word_cnt;
  vga_pkg::coord_t       next_y;
  bus_pkg::adr_t         row_off;
  bus_pkg::data_t        word_q;
  logic                  bank_q;
  logic                  start;

  // line after the one on screen, wrapping at the end of the frame
  assign next_y = (line_y_i == vga_pkg::V_TOTAL - 1'b1) ? '0 : line_y_i + 1'b1;
  assign start  = line_start_i && disp_en_i && (next_y < vga_pkg::V_ACTIVE);

  assign master_cyc_o = (state == vga_pkg::FETCH_BUS);
  assign master_stb_o = master_cyc_o;
  assign master_we_o  = 1'b0;
  assign master_sel_o = '1;
  assign master_adr_o = base_addr_i + row_off + bus_pkg::adr_t'({word_cnt, 2'b00});

  // leftmost pixel sits in the top byte
  assign lane_idx0_o = word_q[31:24];
  assign lane_idx1_o = word_q[23:16];
  assign lane_idx2_o = word_q[15:8];
  assign lane_idx3_o = word_q[7:0];

  assign wr_en_o   = (state == vga_pkg::FETCH_STORE);
  assign wr_bank_o = bank_q;
  assign wr_word_o = word_cnt;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state    <= vga_pkg::FETCH_IDLE;
      word_cnt <= '0;
      row_off  <= '0;
      bank_q   <= 1'b0;
    end else begin
      case (state)
        vga_pkg::FETCH_IDLE: begin
          if (start) begin
            state    <= vga_pkg::FETCH_BUS;
            word_cnt <= '0;
            row_off  <= bus_pkg::adr_t'(next_y) * bus_pkg::adr_t'(vga_pkg::H_ACTIVE);
            bank_q   <= next_y[0];
          end
        end
        vga_pkg::FETCH_BUS: begin
          if (master_ack_i) begin
            state <= vga_pkg::FETCH_LOOKUP;
          end
        end
        // palette read takes this cycle
        vga_pkg::FETCH_LOOKUP: state <= vga_pkg::FETCH_STORE;
        vga_pkg::FETCH_STORE: begin
          if (word_cnt == vga_pkg::lane_addr_t'(vga_pkg::WORDS_PER_LINE - 1)) begin
            state <= vga_pkg::FETCH_IDLE;
          end else begin
            word_cnt <= word_cnt + 1'b1;
            state    <= vga_pkg::FETCH_BUS;
          end
        end
        default: state <= vga_pkg::FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (master_cyc_o && master_ack_i) begin
      word_q <= master_dat_i;
    end
  end

  // a line must be complete before the timing asks for the next one
  assert property (@(posedge clk_i) disable iff (rst_i)
    line_start_i |-> state == vga_pkg::FETCH_IDLE);

  // request held with a steady address until the slave answers
  assert property (@(posedge clk_i) disable iff (rst_i)
    master_stb_o && !master_ack_i |=> master_stb_o && $stable(master_adr_o));

endmodule

//--- logic/palette_ram.sv
`timescale 1ns/1ps

module palette_ram (
  input  logic              clk_i,
  input  logic              we_i,
  input  vga_pkg::pal_idx_t wr_idx_i,
  input  vga_pkg::colour_t  wr_colour_i,
  input  vga_pkg::pal_idx_t rd_idx0_i,
  input  vga_pkg::pal_idx_t rd_idx1_i,
  input  vga_pkg::pal_idx_t rd_idx2_i,
  input  vga_pkg::pal_idx_t rd_idx3_i,
  output vga_pkg::colour_t  rd_colour0_o,
  output vga_pkg::colour_t  rd_colour1_o,
  output vga_pkg::colour_t  rd_colour2_o,
  output vga_pkg::colour_t  rd_colour3_o
);

  vga_pkg::pal_idx_t rd_idx    [vga_pkg::PIX_PER_WORD];
  vga_pkg::colour_t  rd_colour [vga_pkg::PIX_PER_WORD];

  assign rd_idx[0] = rd_idx0_i;
  assign rd_idx[1] = rd_idx1_i;
  assign rd_idx[2] = rd_idx2_i;
  assign rd_idx[3] = rd_idx3_i;

  // one copy per lane, all written together
  for (genvar l = 0; l < vga_pkg::PIX_PER_WORD; l++) begin : g_copy
    vga_pkg::colour_t mem [vga_pkg::PAL_ENTRIES];
    vga_pkg::colour_t q;

    always_ff @(posedge clk_i) begin
      if (we_i) begin
        mem[wr_idx_i] <= wr_colour_i;
      end
      q <= mem[rd_idx[l]];
    end

    assign rd_colour[l] = q;
  end

  assign rd_colour0_o = rd_colour[0];
  assign rd_colour1_o = rd_colour[1];
  assign rd_colour2_o = rd_colour[2];
  assign rd_colour3_o = rd_colour[3];

endmodule

//--- logic/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wr_en_i,
  input  logic                wr_bank_i,
  input  vga_pkg::lane_addr_t wr_word_i,
  input  vga_pkg::colour_t    wr_colour0_i,
  input  vga_pkg::colour_t    wr_colour1_i,
  input  vga_pkg::colour_t    wr_colour2_i,
  input  vga_pkg::colour_t    wr_colour3_i,
  input  vga_pkg::coord_t     pix_x_i,
  input  vga_pkg::coord_t     pix_y_i,
  input  logic                active_i,
  input  logic                disp_en_i,
  output vga_pkg::colour_t    colour_o
);

  vga_pkg::colour_t    mem [2][vga_pkg::PIX_PER_WORD][vga_pkg::WORDS_PER_LINE];
  vga_pkg::colour_t    wr_colour [vga_pkg::PIX_PER_WORD];
  vga_pkg::lane_addr_t rd_word;
  vga_pkg::lane_addr_t rd_lane;

  assign wr_colour[0] = wr_colour0_i;
  assign wr_colour[1] = wr_colour1_i;
  assign wr_colour[2] = wr_colour2_i;
  assign wr_colour[3] = wr_colour3_i;

  // word from x / 4, lane from x mod 4
  assign rd_word = pix_x_i[3:2];
  assign rd_lane = pix_x_i[1:0];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int l = 0; l < vga_pkg::PIX_PER_WORD; l++) begin
        mem[wr_bank_i][l][wr_word_i] <= wr_colour[l];
      end
    end
  end

  // displayed bank follows the parity of the current line
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      colour_o <= '0;
    end else if (active_i && disp_en_i) begin
      colour_o <= mem[pix_y_i[0]][rd_lane][rd_word];
    end else begin
      colour_o <= '0;
    end
  end

endmodule

//--- logic/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
  input  logic            clk_i,
  input  logic            rst_i,
  output logic            hs_o,
  output logic            vs_o,
  output logic            blank_n_o,
  output logic            active_o,
  output vga_pkg::coord_t pix_x_o,
  output vga_pkg::coord_t pix_y_o,
  output logic            line_start_o,
  output vga_pkg::coord_t line_y_o
);

  vga_pkg::coord_t h_cnt;
  vga_pkg::coord_t v_cnt;
  logic            h_last;
  logic            h_sync_zone;
  logic            v_sync_zone;

  assign h_last = (h_cnt == vga_pkg::H_TOTAL - 1'b1);

  assign h_sync_zone = (h_cnt >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
                       (h_cnt <  vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC);
  assign v_sync_zone = (v_cnt >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
                       (v_cnt <  vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC);

  // these lead the registered outputs by one cycle
  assign active_o     = (h_cnt < vga_pkg::H_ACTIVE) && (v_cnt < vga_pkg::V_ACTIVE);
  assign pix_x_o      = h_cnt;
  assign pix_y_o      = v_cnt;
  assign line_start_o = (h_cnt == '0);
  assign line_y_o     = v_cnt;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      h_cnt     <= '0;
      v_cnt     <= '0;
      hs_o      <= 1'b1;
      vs_o      <= 1'b1;
      blank_n_o <= 1'b0;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == vga_pkg::V_TOTAL - 1'b1) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      // syncs are active low
      hs_o      <= !h_sync_zone;
      vs_o      <= !v_sync_zone;
      blank_n_o <= active_o;
    end
  end

endmodule

//--- logic/vga_top.sv
`timescale 1ns/1ps

module vga_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  bus_pkg::reg_adr_t slave_adr_i,
  input  bus_pkg::data_t    slave_dat_i,
  input  bus_pkg::sel_t     slave_sel_i,
  input  logic              slave_we_i,
  input  logic              slave_cyc_i,
  input  logic              slave_stb_i,
  output bus_pkg::data_t    slave_dat_o,
  output logic              slave_ack_o,
  output bus_pkg::adr_t     master_adr_o,
  output logic              master_cyc_o,
  output logic              master_stb_o,
  output logic              master_we_o,
  output bus_pkg::sel_t     master_sel_o,
  input  bus_pkg::data_t    master_dat_i,
  input  logic              master_ack_i,
  output logic              hs_o,
  output logic              vs_o,
  output logic              blank_n_o,
  output logic [7:0]        r_o,
  output logic [7:0]        g_o,
  output logic [7:0]        b_o
);

  bus_pkg::adr_t       base_addr;
  logic                disp_en;
  logic                pal_we;
  vga_pkg::pal_idx_t   pal_wr_idx;
  vga_pkg::colour_t    pal_wr_colour;
  vga_pkg::pal_idx_t   lane_idx [4];
  vga_pkg::colour_t    lane_colour [4];
  logic                wr_en;
  logic                wr_bank;
  vga_pkg::lane_addr_t wr_word;
  logic                active;
  vga_pkg::coord_t     pix_x;
  vga_pkg::coord_t     pix_y;
  logic                line_start;
  vga_pkg::coord_t     line_y;
  vga_pkg::colour_t    colour;

  vga_regs i_regs (
    .clk_i, .rst_i, .slave_adr_i, .slave_dat_i, .slave_sel_i, .slave_we_i,
    .slave_cyc_i, .slave_stb_i, .slave_dat_o, .slave_ack_o,
    .base_addr_o(base_addr), .disp_en_o(disp_en), .pal_we_o(pal_we),
    .pal_wr_idx_o(pal_wr_idx), .pal_wr_colour_o(pal_wr_colour)
  );

  vga_fetch i_fetch (
    .clk_i, .rst_i, .base_addr_i(base_addr), .disp_en_i(disp_en),
    .line_start_i(line_start), .line_y_i(line_y), .master_dat_i, .master_ack_i,
    .master_adr_o, .master_cyc_o, .master_stb_o, .master_we_o, .master_sel_o,
    .lane_idx0_o(lane_idx[0]), .lane_idx1_o(lane_idx[1]),
    .lane_idx2_o(lane_idx[2]), .lane_idx3_o(lane_idx[3]),
    .wr_en_o(wr_en), .wr_bank_o(wr_bank), .wr_word_o(wr_word)
  );

  palette_ram i_palette (
    .clk_i, .we_i(pal_we), .wr_idx_i(pal_wr_idx), .wr_colour_i(pal_wr_colour),
    .rd_idx0_i(lane_idx[0]), .rd_idx1_i(lane_idx[1]),
    .rd_idx2_i(lane_idx[2]), .rd_idx3_i(lane_idx[3]),
    .rd_colour0_o(lane_colour[0]), .rd_colour1_o(lane_colour[1]),
    .rd_colour2_o(lane_colour[2]), .rd_colour3_o(lane_colour[3])
  );

  line_buffer i_line_buffer (
    .clk_i, .rst_i, .wr_en_i(wr_en), .wr_bank_i(wr_bank), .wr_word_i(wr_word),
    .wr_colour0_i(lane_colour[0]), .wr_colour1_i(lane_colour[1]),
    .wr_colour2_i(lane_colour[2]), .wr_colour3_i(lane_colour[3]),
    .pix_x_i(pix_x), .pix_y_i(pix_y), .active_i(active), .disp_en_i(disp_en),
    .colour_o(colour)
  );

  vga_timing i_timing (
    .clk_i, .rst_i, .hs_o, .vs_o, .blank_n_o, .active_o(active),
    .pix_x_o(pix_x), .pix_y_o(pix_y), .line_start_o(line_start), .line_y_o(line_y)
  );

  assign r_o = colour[23:16];
  assign g_o = colour[15:8];
  assign b_o = colour[7:0];

endmodule

//--- tb/tb_vga.sv
`timescale 1ns/1ps

module tb_vga;

  localparam int LINE_CYCLES    = 48;
  localparam int ACTIVE_PIXELS  = 16;
  localparam int ACTIVE_LINES   = 4;
  localparam int FRAME_CYCLES   = 8 * LINE_CYCLES;
  localparam int VS_LOW_CYCLES  = 2 * LINE_CYCLES;
  localparam int LINE_BYTES     = 16;
  localparam int ACK_LIMIT      = 4;
  // reset and register setup, then roughly six and a half frames of waiting
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int STIM_WORDS     = 25;

  // what the monitor expects on the colour outputs
  localparam int MODE_NONE = 0;
  localparam int MODE_PIX  = 1;
  localparam int MODE_OFF  = 2;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic [10:0] slave_adr;
  logic [31:0] slave_wdat;
  logic [3:0]  slave_sel;
  logic        slave_we;
  logic        slave_cyc;
  logic        slave_stb;
  logic [31:0] slave_rdat;
  logic        slave_ack;
  logic [31:0] master_adr;
  logic        master_cyc;
  logic        master_stb;
  logic        master_we;
  logic [3:0]  master_sel;
  logic [31:0] master_dat = '0;
  logic        master_ack = 1'b0;
  logic        hs;
  logic        vs;
  logic        blank_n;
  logic [7:0]  r;
  logic [7:0]  g;
  logic [7:0]  b;

  logic [31:0] stim [STIM_WORDS];
  logic [23:0] pal_model [256];
  logic [31:0] base_model;
  logic [31:0] last_adr;
  logic [31:0] lfsr = 32'hb4ad442d;
  logic [1:0]  delay;
  logic        serving = 1'b0;
  int          mode = MODE_OFF;
  int          cycles = 0;
  int          frame_cnt = 0;
  logic        hs_prev = 1'b1;
  logic        vs_prev = 1'b1;
  logic        blank_prev = 1'b0;
  logic        hs_seen = 1'b0;
  logic        vs_seen = 1'b0;
  int          hs_cycles = 0;
  int          line_blank = 0;
  int          frame_cycles = 0;
  int          vs_low = 0;
  int          active_lines = 0;
  int          pix_x = 0;
  int          pix_line = 0;

  vga_top i_dut (
    .clk_i(clk_i), .rst_i(rst_i),
    .slave_adr_i(slave_adr), .slave_dat_i(slave_wdat), .slave_sel_i(slave_sel),
    .slave_we_i(slave_we), .slave_cyc_i(slave_cyc), .slave_stb_i(slave_stb),
    .slave_dat_o(slave_rdat), .slave_ack_o(slave_ack),
    .master_adr_o(master_adr), .master_cyc_o(master_cyc), .master_stb_o(master_stb),
    .master_we_o(master_we), .master_sel_o(master_sel),
    .master_dat_i(master_dat), .master_ack_i(master_ack),
    .hs_o(hs), .vs_o(vs), .blank_n_o(blank_n), .r_o(r), .g_o(g), .b_o(b)
  );

  always #20 clk_i = ~clk_i;

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1, new bit shifted in at the bottom
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // each byte is a palette index 0..7 mixed from the address
  function automatic logic [31:0] fb_word(input logic [31:0] adr);
    logic [31:0] w;
    int          sum;
    w = '0;
    for (int k = 0; k < 4; k++) begin
      sum = int'(adr[1:0]) + int'(adr[3:2]) + 3 * int'(adr[5:4]) +
            $countones(adr[31:6]) + 5 * k;
      w[31 - 8 * k -: 8] = 8'(sum % 8);
    end
    return w;
  endfunction

  function automatic logic [23:0] expected_colour(input int row, input int x);
    logic [31:0] word;
    logic [7:0]  idx;
    word = fb_word(base_model + 32'(row * LINE_BYTES + (x / 4) * 4));
    // leftmost pixel of a word is its most significant byte
    idx = word[31 - 8 * (x % 4) -: 8];
    return pal_model[idx];
  endfunction

  task automatic bus_access(input logic [10:0] adr, input logic we, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdata);
    int waited;
    slave_adr  = adr;
    slave_wdat = dat;
    slave_sel  = sel;
    slave_we   = we;
    slave_cyc  = 1'b1;
    slave_stb  = 1'b1;
    waited     = 0;
    @(negedge clk_i);
    while (!slave_ack && waited < ACK_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!slave_ack) begin
      report_failure("slave bus access was never acknowledged");
    end
    // ack comes in the cycle after the request is taken
    check_value("slave_ack_o extra wait cycles", 32'(waited), 32'h0);
    rdata     = slave_rdat;
    slave_cyc = 1'b0;
    slave_stb = 1'b0;
    slave_we  = 1'b0;
    @(negedge clk_i);
    if (slave_ack) begin
      report_failure("slave bus gave more than one acknowledge for one access");
    end
  endtask

  task automatic write_reg(input logic [10:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
    logic [31:0] unused_rd;
    bus_access(adr, 1'b1, dat, sel, unused_rd);
  endtask

  task automatic read_check(input string name, input logic [10:0] adr,
                            input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(adr, 1'b0, '0, 4'hf, rd);
    check_value(name, rd, exp);
  endtask

  task automatic write_palette(input int idx, input logic [31:0] colour);
    write_reg(11'(idx), colour, 4'hf);
    pal_model[idx] = colour[23:0];
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target) begin
      @(negedge clk_i);
    end
  endtask

  // framebuffer model with 0 to 3 cycles of ack delay
  always @(negedge clk_i) begin
    if (rst_i) begin
      master_ack = 1'b0;
      serving    = 1'b0;
    end else if (master_ack) begin
      master_ack = 1'b0;
    end else if (master_cyc && master_stb) begin
      if (!serving) begin
        lfsr     = lfsr_next(lfsr);
        delay[0] = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        delay[1] = lfsr[0];
        serving  = 1'b1;
      end
      if (delay == 2'd0) begin
        master_dat = fb_word(master_adr);
        master_ack = 1'b1;
        last_adr   = master_adr;
        serving    = 1'b0;
      end else begin
        delay = delay - 1'b1;
      end
    end
  end

  // sync timing and pixel monitor, sampled away from the rising edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (hs_prev && !hs) begin
        if (hs_seen) begin
          check_value("hs_o period", hs_cycles, LINE_CYCLES);
          if (line_blank != 0) begin
            check_value("blank_n_o high cycles per line", line_blank, ACTIVE_PIXELS);
          end
        end
        hs_seen    = 1'b1;
        hs_cycles  = 0;
        line_blank = 0;
      end
      if (vs_prev && !vs) begin
        if (vs_seen) begin
          check_value("vs_o period", frame_cycles, FRAME_CYCLES);
          check_value("vs_o low cycles", vs_low, VS_LOW_CYCLES);
          check_value("active lines per frame", active_lines, ACTIVE_LINES);
        end
        vs_seen      = 1'b1;
        frame_cycles = 0;
        vs_low       = 0;
        active_lines = 0;
        pix_line     = 0;
        frame_cnt++;
      end
      if (blank_prev && !blank_n) begin
        active_lines++;
        pix_line++;
        pix_x = 0;
      end
      hs_cycles++;
      frame_cycles++;
      if (!vs) begin
        vs_low++;
      end
      if (blank_n) begin
        line_blank++;
        if (mode == MODE_PIX) begin
          check_value($sformatf("{r_o,g_o,b_o} line %0d pixel %0d", pix_line, pix_x),
                      32'({r, g, b}), 32'(expected_colour(pix_line, pix_x)));
        end else if (mode == MODE_OFF) begin
          check_value("{r_o,g_o,b_o} while disabled", 32'({r, g, b}), 32'h0);
        end
        pix_x++;
      end else begin
        check_value("{r_o,g_o,b_o} during blanking", 32'({r, g, b}), 32'h0);
      end
      if (master_cyc) begin
        check_value("master_stb_o", 32'(master_stb), 32'h1);
        check_value("master_we_o", 32'(master_we), 32'h0);
        check_value("master_sel_o", 32'(master_sel), 32'hf);
      end
      if (mode == MODE_OFF) begin
        check_value("master_cyc_o while disabled", 32'(master_cyc), 32'h0);
      end
      hs_prev    = hs;
      vs_prev    = vs;
      blank_prev = blank_n;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      report_failure("the run hit its cycle limit before all tests finished");
    end
  end

  initial begin
    rst_i      = 1'b1;
    slave_adr  = '0;
    slave_wdat = '0;
    slave_sel  = '0;
    slave_we   = 1'b0;
    slave_cyc  = 1'b0;
    slave_stb  = 1'b0;
    $readmemh("tb/vga_stim.txt", stim);
    if ($isunknown(stim[STIM_WORDS - 1])) begin
      report_failure("the stimulus file tb/vga_stim.txt could not be read");
    end
    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;
    check_value("hs_o after reset", 32'(hs), 32'h1);
    check_value("vs_o after reset", 32'(vs), 32'h1);
    check_value("blank_n_o after reset", 32'(blank_n), 32'h0);
    check_value("master_cyc_o after reset", 32'(master_cyc), 32'h0);

    for (int i = 0; i < 8; i++) begin
      write_palette(i, stim[i]);
    end
    read_check("base after reset", 11'h500, stim[12]);
    write_reg(11'h500, stim[13], stim[14][3:0]);
    read_check("base after low half write", 11'h500, stim[15]);
    write_reg(11'h500, stim[16], stim[17][3:0]);
    read_check("base after high half write", 11'h500, stim[18]);
    read_check("unmapped register", 11'h300, 32'h0);
    base_model = stim[18];
    // one full frame with the display still off
    wait_frames(1);

    mode = MODE_NONE;
    write_reg(11'h501, stim[20], stim[21][3:0]);
    read_check("ctrl after enable", 11'h501, stim[22]);
    wait_frames(1);
    mode = MODE_PIX;
    wait_frames(1);
    mode = MODE_NONE;
    check_value("master_adr_o last word", last_adr, base_model + 32'(3 * LINE_BYTES + 12));

    // new base and palette entries 0..3 while running
    write_reg(11'h500, stim[19], 4'hf);
    read_check("base after full write", 11'h500, stim[19]);
    base_model = stim[19];
    for (int i = 0; i < 4; i++) begin
      write_palette(i, stim[8 + i]);
    end
    wait_frames(1);
    mode = MODE_PIX;
    wait_frames(1);
    mode = MODE_NONE;
    check_value("master_adr_o last word", last_adr, base_model + 32'(3 * LINE_BYTES + 12));

    write_reg(11'h501, stim[23], stim[21][3:0]);
    read_check("ctrl after disable", 11'h501, stim[24]);
    wait_frames(1);
    mode = MODE_OFF;
    wait_frames(1);

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- tb/vga_stim.txt
// one 32-bit hex word per line: palette set A (entries 0-7), palette set B (entries 0-3),
// base reset value, base writes as data/sel/readback, base B, ctrl data/sel/readback
00102030
00FF0000
0000FF00
000000FF
00808080
00123456
00ABCDEF
00F0E0D0
// palette set B
000F0F0F
0055AA55
00AA55AA
0013579B
// base register
C0000000
DEAD1000
00000003
C0001000
0000BEEF
0000000C
00001000
00002200
// control register enable, then disable
FFFFFF01
00000001
00000001
FFFFFF00
00000000

//--- files.f
logic/vga_pkg.sv
logic/bus_pkg.sv
logic/vga_regs.sv
logic/vga_fetch.sv
logic/palette_ram.sv
logic/line_buffer.sv
logic/vga_timing.sv
logic/vga_top.sv
tb/tb_vga.sv

//--- Makefile
.PHONY: run clean

run:
	verilator --binary --assert --top-module tb_vga -f files.f
	-./obj_dir/Vtb_vga > sim.log 2>&1
	cat sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
